//--- dino_input_decode.sv
`timescale 1ns/1ps

module dino_input_decode
(
        input  logic                clk,
        input  logic                rstn,
        input  logic                jump,
        input  logic                down,
        input  logic                landed,
        output dino_pkg::dino_cmd_t cmd
);

        logic jump_go;
        logic duck_go;

        // No take-off while ducking
        assign jump_go = jump && !cmd.ducking && !cmd.jumping;

        // Ground only, and a fresh jump wins over a fresh duck
        assign duck_go = down && !cmd.jumping && !jump_go;

        always_ff @(posedge clk or posedge rstn)
        begin
                if (rstn)
                begin
                        cmd <= '0;
                end
                else
                begin
                        if (landed)
                        begin
                                cmd.jumping <= 1'b0;
                        end
                        else if (jump_go)
                        begin
                                cmd.jumping <= 1'b1;
                        end

                        // Held duck drops as soon as down is released
                        cmd.ducking <= duck_go;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Checks
        ////////////////////////////////////////////////////////////////////////////

        // Landing and button arbitration never leave both flags set
        ap_exclusive: assert property (@(posedge clk) disable iff (rstn)
                !(cmd.jumping && cmd.ducking));

endmodule

//--- dino_jump_exec.sv
`timescale 1ns/1ps

module dino_jump_exec
(
        input  logic                clk,
        input  logic                rstn,
        input  dino_pkg::dino_cmd_t cmd,
        output dino_pkg::dino_y_t   y,
        output logic                landed
);

        logic [dino_pkg::STEP_W-1:0] step_cnt;
        logic [dino_pkg::STEP_W-1:0] step_len;
        logic                        falling;
        logic                        step_hit;

        ////////////////////////////////////////////////////////////////////////////
        // Band select
        ////////////////////////////////////////////////////////////////////////////

        // Slower steps the higher the character is
        always_comb
        begin
                if (y >= dino_pkg::BAND_LOW_Y)
                begin
                        step_len = dino_pkg::STEP_LOW;
                end
                else if (y >= dino_pkg::BAND_MID_Y)
                begin
                        step_len = dino_pkg::STEP_MID;
                end
                else if (y >= dino_pkg::BAND_HIGH_Y)
                begin
                        step_len = dino_pkg::STEP_HIGH;
                end
                else
                begin
                        step_len = dino_pkg::STEP_TOP;
                end
        end

        assign step_hit = cmd.jumping && ((step_cnt + 1'b1) == step_len);

        // One extra interval spent on the ground line ends the jump
        assign landed = step_hit && falling && (y == dino_pkg::GROUND_Y);

        ////////////////////////////////////////////////////////////////////////////
        // Vertical motion
        ////////////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk or posedge rstn)
        begin
                if (rstn)
                begin
                        y        <= dino_pkg::GROUND_Y;
                        falling  <= 1'b0;
                        step_cnt <= '0;
                end
                else if (!cmd.jumping)
                begin
                        falling  <= 1'b0;
                        step_cnt <= '0;
                end
                else if (step_hit)
                begin
                        step_cnt <= '0;
                        if (!falling)
                        begin
                                y <= y - 1'b1;
                                // Turn around on reaching the apex
                                if (y == dino_pkg::APEX_Y + 9'd1)
                                begin
                                        falling <= 1'b1;
                                end
                        end
                        else if (y != dino_pkg::GROUND_Y)
                        begin
                                y <= y + 1'b1;
                        end
                        else
                        begin
                                falling <= 1'b0;
                        end
                end
                else
                begin
                        step_cnt <= step_cnt + 1'b1;
                end
        end

        ap_y_range: assert property (@(posedge clk) disable iff (rstn)
                (y >= dino_pkg::APEX_Y) && (y <= dino_pkg::GROUND_Y));

        // After landing the decoder has dropped the jump and y rests on the ground line
        ap_land: assert property (@(posedge clk) disable iff (rstn)
                landed |=> !cmd.jumping && (y == dino_pkg::GROUND_Y));

endmodule

//--- dino_pkg.sv
package dino_pkg;

        ////////////////////////////////////////////////////////////////////////////
        // Coordinate types
        ////////////////////////////////////////////////////////////////////////////

        typedef logic [9:0] dino_x_t;
        typedef logic [8:0] dino_y_t;

        // Screen rows grow downward, so a smaller y is higher
        localparam dino_x_t X_POS       = 10'd41;
        localparam dino_y_t GROUND_Y    = 9'd329;
        localparam dino_y_t APEX_Y      = 9'd200;

        // Height bands for the easing of the jump
        localparam dino_y_t BAND_LOW_Y  = 9'd270;
        localparam dino_y_t BAND_MID_Y  = 9'd240;
        localparam dino_y_t BAND_HIGH_Y = 9'd215;

        ////////////////////////////////////////////////////////////////////////////
        // Timing
        ////////////////////////////////////////////////////////////////////////////

        localparam int STEP_W  = 4;
        localparam int FRAME_W = 5;

        // Cycles per one pixel step
        localparam logic [STEP_W-1:0] STEP_LOW  = 4'd3;
        localparam logic [STEP_W-1:0] STEP_MID  = 4'd4;
        localparam logic [STEP_W-1:0] STEP_HIGH = 4'd5;
        localparam logic [STEP_W-1:0] STEP_TOP  = 4'd6;

        localparam logic [FRAME_W-1:0] FRAME_PERIOD = 5'd16;

        typedef enum logic [1:0] {
                POSE_RUN_A = 2'd0,
                POSE_RUN_B = 2'd1,
                POSE_DUCK  = 2'd2
        } dino_pose_e;

        typedef struct packed {
                logic jumping;
                logic ducking;
        } dino_cmd_t;

        typedef struct packed {
                dino_x_t    x;
                dino_y_t    y;
                dino_pose_e pose;
                logic       airborne;
        } dino_status_t;

endpackage

//--- dino_pose_result.sv
`timescale 1ns/1ps

module dino_pose_result
(
        input  logic                   clk,
        input  logic                   rstn,
        input  dino_pkg::dino_cmd_t    cmd,
        input  dino_pkg::dino_y_t      y,
        output dino_pkg::dino_status_t status
);

        logic [dino_pkg::FRAME_W-1:0] frame_cnt;
        logic                         frame;
        dino_pkg::dino_pose_e         pose_q;
        logic                         airborne_q;

        ////////////////////////////////////////////////////////////////////////////
        // Run animation timer
        ////////////////////////////////////////////////////////////////////////////

        // Free running, independent of jump and duck
        always_ff @(posedge clk or posedge rstn)
        begin
                if (rstn)
                begin
                        frame_cnt <= '0;
                        frame     <= 1'b0;
                end
                else if (frame_cnt == dino_pkg::FRAME_PERIOD - 1'b1)
                begin
                        frame_cnt <= '0;
                        frame     <= ~frame;
                end
                else
                begin
                        frame_cnt <= frame_cnt + 1'b1;
                end
        end

        always_ff @(posedge clk or posedge rstn)
        begin
                if (rstn)
                begin
                        pose_q     <= dino_pkg::POSE_RUN_A;
                        airborne_q <= 1'b0;
                end
                else
                begin
                        if (cmd.ducking)
                        begin
                                pose_q <= dino_pkg::POSE_DUCK;
                        end
                        else
                        begin
                                pose_q <= frame ? dino_pkg::POSE_RUN_B : dino_pkg::POSE_RUN_A;
                        end
                        airborne_q <= cmd.jumping;
                end
        end

        // Position passes straight through
        assign status = '{x: dino_pkg::X_POS, y: y, pose: pose_q, airborne: airborne_q};

endmodule

//--- dino_runner_top.sv
`timescale 1ns/1ps

module dino_runner_top
(
        input  logic                   clk,
        input  logic                   rstn,
        input  logic                   jump,
        input  logic                   down,
        output dino_pkg::dino_status_t status
);

        dino_pkg::dino_cmd_t cmd;
        dino_pkg::dino_y_t   y;
        logic                landed;

        ////////////////////////////////////////////////////////////////////////////
        // Decode, execute, result
        ////////////////////////////////////////////////////////////////////////////

        dino_input_decode u_decode
        (
                .clk    (clk),
                .rstn   (rstn),
                .jump   (jump),
                .down   (down),
                .landed (landed),
                .cmd    (cmd)
        );

        // Landing feeds back to the decoder
        dino_jump_exec u_exec
        (
                .clk    (clk),
                .rstn   (rstn),
                .cmd    (cmd),
                .y      (y),
                .landed (landed)
        );

        dino_pose_result u_result
        (
                .clk    (clk),
                .rstn   (rstn),
                .cmd    (cmd),
                .y      (y),
                .status (status)
        );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the runner testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_dino_runner -o tb_sim \
        && ./obj_dir/tb_sim > sim.log 2>&1 \
        || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

//--- tb_dino_runner.sv
`timescale 1ns/1ps

module tb_dino_runner;

        logic                   clk;
        logic                   rstn;
        logic                   jump;
        logic                   down;
        dino_pkg::dino_status_t status;

        int error_count;
        int test_errors;
        int pass_tests;
        int fail_tests;

        // Per-test statistics gathered by the monitor
        int epoch;
        int seen_epoch;
        int air_cycles;
        int min_y;
        int prev_y;
        int cur_y;
        int bad_steps;
        bit duck_seen;

        dino_runner_top dut0
        (
                .clk    (clk),
                .rstn   (rstn),
                .jump   (jump),
                .down   (down),
                .status (status)
        );

        initial
        begin
                clk = 1'b0;
                forever
                begin
                        #2 clk = ~clk;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Reference model
        ////////////////////////////////////////////////////////////////////////////

        function automatic int step_len_at(input int y);
                if (y >= int'(dino_pkg::BAND_LOW_Y))
                        return int'(dino_pkg::STEP_LOW);
                if (y >= int'(dino_pkg::BAND_MID_Y))
                        return int'(dino_pkg::STEP_MID);
                if (y >= int'(dino_pkg::BAND_HIGH_Y))
                        return int'(dino_pkg::STEP_HIGH);
                return int'(dino_pkg::STEP_TOP);
        endfunction

        // Airborne cycles of one full jump, apex returned alongside
        function automatic int jump_model(output int apex);
                int  y;
                int  cycles;
                bit  falling;
                bit  done;
                y       = int'(dino_pkg::GROUND_Y);
                cycles  = 0;
                falling = 1'b0;
                done    = 1'b0;
                apex    = y;
                while (!done)
                begin
                        cycles += step_len_at(y);
                        if (!falling)
                        begin
                                y--;
                                if (y == int'(dino_pkg::APEX_Y))
                                        falling = 1'b1;
                        end
                        else if (y != int'(dino_pkg::GROUND_Y))
                                y++;
                        else
                                done = 1'b1;
                        if (y < apex)
                                apex = y;
                end
                return cycles;
        endfunction

        ////////////////////////////////////////////////////////////////////////////
        // Monitor
        ////////////////////////////////////////////////////////////////////////////

        always @(negedge clk)
        begin
                if (epoch != seen_epoch)
                begin
                        seen_epoch = epoch;
                        air_cycles = 0;
                        bad_steps  = 0;
                        duck_seen  = 1'b0;
                        min_y      = int'(status.y);
                        prev_y     = int'(status.y);
                end
                cur_y = int'(status.y);
                if (status.airborne)
                        air_cycles++;
                if (cur_y < min_y)
                        min_y = cur_y;
                if (status.pose == dino_pkg::POSE_DUCK)
                        duck_seen = 1'b1;
                if ((cur_y - prev_y > 1) || (prev_y - cur_y > 1))
                        bad_steps++;
                prev_y = cur_y;
        end

        task automatic tick();
                @(posedge clk);
                #1;
        endtask

        task automatic report_mismatch(input string name, input int exp, input int act);
                $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
                error_count++;
                test_errors++;
        endtask

        task automatic report_problem(input string name, input string what);
                $display("[FAIL] %s %s", name, what);
                error_count++;
                test_errors++;
        endtask

        task automatic close_test(input string name);
                if (test_errors == 0)
                begin
                        pass_tests++;
                        $display("[ OK ] %s", name);
                end
                else
                begin
                        fail_tests++;
                        $display("[FAIL] %s ended with %0d error(s)", name, test_errors);
                end
                test_errors = 0;
                epoch++;
        endtask

        task automatic pulse_jump(input int hold);
                jump = 1'b1;
                repeat (hold) tick();
                jump = 1'b0;
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Stimulus and checks
        ////////////////////////////////////////////////////////////////////////////

        initial
        begin
                int                   exp_air;
                int                   exp_apex;
                int                   hold;
                int                   run_len;
                int                   toggles;
                bit                   first_run;
                dino_pkg::dino_pose_e prev_pose;
                dino_pkg::dino_pose_e cur_pose;

                rstn        = 1'b1;
                jump        = 1'b0;
                down        = 1'b0;
                error_count = 0;
                test_errors = 0;
                pass_tests  = 0;
                fail_tests  = 0;
                epoch       = 0;
                seen_epoch  = 0;
                void'($urandom(32'hff4b4953));
                exp_air = jump_model(exp_apex);

                repeat (4) @(posedge clk);
                #1 rstn = 1'b0;
                tick();

                if (int'(status.x) != int'(dino_pkg::X_POS))
                        report_mismatch("reset_state x", int'(dino_pkg::X_POS), int'(status.x));
                if (int'(status.y) != int'(dino_pkg::GROUND_Y))
                        report_mismatch("reset_state y", int'(dino_pkg::GROUND_Y), int'(status.y));
                if (status.airborne != 1'b0)
                        report_mismatch("reset_state airborne", 0, int'(status.airborne));
                if (status.pose != dino_pkg::POSE_RUN_A)
                        report_mismatch("reset_state pose", int'(dino_pkg::POSE_RUN_A),
                                        int'(status.pose));
                close_test("reset_state");

                // Full jump
                tick();
                hold = 1 + int'($urandom % 6);
                pulse_jump(hold);
                wait (status.airborne == 1'b1);
                wait (status.airborne == 1'b0);
                tick();
                tick();
                if (air_cycles != exp_air)
                        report_mismatch("full_jump airborne cycles", exp_air, air_cycles);
                if (min_y != exp_apex)
                        report_mismatch("full_jump apex", exp_apex, min_y);
                if (int'(status.y) != int'(dino_pkg::GROUND_Y))
                        report_mismatch("full_jump landing y", int'(dino_pkg::GROUND_Y),
                                        int'(status.y));
                if (bad_steps != 0)
                        report_problem("full_jump", "y moved by more than one pixel in a cycle");
                close_test("full_jump");

                // Duck on the ground, then a refused jump
                tick();
                down = 1'b1;
                tick();
                if (status.pose == dino_pkg::POSE_DUCK)
                        report_problem("duck_on_ground", "duck pose appeared without delay");
                tick();
                if (status.pose != dino_pkg::POSE_DUCK)
                        report_mismatch("duck_on_ground pose", int'(dino_pkg::POSE_DUCK),
                                        int'(status.pose));
                hold = 4 + int'($urandom % 12);
                repeat (hold) tick();
                pulse_jump(1 + int'($urandom % 6));
                repeat (4) tick();
                down = 1'b0;
                repeat (3) tick();
                if (air_cycles != 0)
                        report_mismatch("duck_on_ground airborne cycles", 0, air_cycles);
                if (status.pose == dino_pkg::POSE_DUCK)
                        report_problem("duck_on_ground", "run pose did not return after release");
                close_test("duck_on_ground");

                // Duck request during a jump
                tick();
                pulse_jump(1 + int'($urandom % 6));
                wait (status.airborne == 1'b1);
                repeat (20) tick();
                hold = 4 + int'($urandom % 12);
                down = 1'b1;
                repeat (hold) tick();
                down = 1'b0;
                wait (status.airborne == 1'b0);
                tick();
                tick();
                if (duck_seen)
                        report_problem("duck_in_air", "duck pose appeared while airborne");
                if (air_cycles != exp_air)
                        report_mismatch("duck_in_air airborne cycles", exp_air, air_cycles);
                close_test("duck_in_air");

                // Run animation over eight frames
                tick();
                prev_pose = status.pose;
                run_len   = 1;
                toggles   = 0;
                first_run = 1'b1;
                repeat (8 * int'(dino_pkg::FRAME_PERIOD) - 1)
                begin
                        tick();
                        cur_pose = status.pose;
                        if (cur_pose == dino_pkg::POSE_DUCK)
                                report_problem("run_animation", "duck pose without down");
                        if (cur_pose == prev_pose)
                                run_len++;
                        else
                        begin
                                if (!first_run && run_len != int'(dino_pkg::FRAME_PERIOD))
                                        report_mismatch("run_animation frame length",
                                                        int'(dino_pkg::FRAME_PERIOD), run_len);
                                first_run = 1'b0;
                                run_len   = 1;
                                toggles++;
                        end
                        prev_pose = cur_pose;
                end
                if (toggles < 7)
                        report_mismatch("run_animation frame changes", 7, toggles);
                close_test("run_animation");

                $display("tests passed %0d, tests failed %0d, errors %0d",
                         pass_tests, fail_tests, error_count);
                if (error_count == 0)
                        $display("Simulation completed successfully");
                else
                        $display("Simulation failed");
                $finish;
        end

        // Limit scaled from the modelled jump length
        initial
        begin
                int apex;
                int limit;
                limit = 8 * jump_model(apex) + 2000;
                repeat (limit) @(posedge clk);
                $display("Timeout after %0d cycles waiting for the DUT", limit);
                $display("Simulation failed");
                $finish;
        end

endmodule

//--- verilog.f
dino_pkg.sv
dino_input_decode.sv
dino_jump_exec.sv
dino_pose_result.sv
dino_runner_top.sv
tb_dino_runner.sv
